// File: Bender.yml
package:
  name: mips_decode_stage

sources:
  - source/mips_decode_pkg.sv
  - source/extract_instruction.sv
  - source/rtype_decoder.sv
  - source/regimm_decoder.sv
  - source/main_decoder.sv
  - source/decode_stage_reg.sv
  - source/decode_stage.sv
  - target: test
    files:
      - verification/decode_stage_properties.sv
      - verification/tb_decode_stage.sv

// File: source/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage
    import mips_decode_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic [31:0] instr,
    input  wire logic        instr_valid,
    input  wire logic        stall,
    input  wire logic        flush,
    output control_t         ctl,
    output unpack_t          fields,
    output logic             ctl_valid
);

    unpack_t  unpack;
    control_t rtype_ctl;
    control_t regimm_ctl;
    control_t ctl_next;

    // ************************************************************
    // combinational decode.
    // ************************************************************

    extract_instruction u_extract (
        .instruction (instr),
        .unpack      (unpack)
    );

    rtype_decoder u_rtype (
        .unpack (unpack),
        .ctl    (rtype_ctl)
    );

    regimm_decoder u_regimm (
        .unpack (unpack),
        .ctl    (regimm_ctl)
    );

    main_decoder u_main (
        .unpack     (unpack),
        .rtype_ctl  (rtype_ctl),
        .regimm_ctl (regimm_ctl),
        .ctl        (ctl_next)
    );

    // ************************************************************
    // decode pipeline registers.
    // ************************************************************

    decode_stage_reg #(.payload_t(control_t)) u_ctl_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_valid  (instr_valid),
        .stall       (stall),
        .flush       (flush),
        .d           (ctl_next),
        .reset_value (CONTROL_DEFAULT),
        .q           (ctl),
        .q_valid     (ctl_valid)
    );

    // valid already comes from the control register.
    decode_stage_reg #(.payload_t(unpack_t)) u_field_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_valid  (instr_valid),
        .stall       (stall),
        .flush       (flush),
        .d           (unpack),
        .reset_value ('0),
        .q           (fields),
        .q_valid     ()
    );

endmodule

`default_nettype wire

// File: source/decode_stage_reg.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     load_valid,
    input  wire logic     stall,
    input  wire logic     flush,
    input  wire payload_t d,
    input  wire payload_t reset_value,
    output payload_t      q,
    output logic          q_valid
);

    // flush wins over stall. stall holds everything.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q       <= reset_value;
            q_valid <= 1'b0;
        end else if (flush) begin
            q       <= reset_value;
            q_valid <= 1'b0;
        end else if (!stall) begin
            q       <= d;
            q_valid <= load_valid;
        end
    end

endmodule

`default_nettype wire

// File: source/extract_instruction.sv
`timescale 1ns/10ps
`default_nettype none

module extract_instruction
    import mips_decode_pkg::*;
(
    input  wire logic [31:0] instruction,
    output unpack_t          unpack
);

    // standard mips field layout, shared by all decoders.
    assign unpack.opcode = instruction[31:26];
    assign unpack.rs     = instruction[25:21];
    assign unpack.rt     = instruction[20:16];
    assign unpack.rd     = instruction[15:11];
    assign unpack.shamt  = instruction[10:6];
    assign unpack.funct  = instruction[5:0];
    assign unpack.imm    = instruction[15:0];

endmodule

`default_nettype wire

// File: source/main_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module main_decoder
    import mips_decode_pkg::*;
(
    input  wire unpack_t  unpack,
    input  wire control_t rtype_ctl,
    input  wire control_t regimm_ctl,
    output control_t      ctl
);

    always_comb begin
        ctl = CONTROL_DEFAULT;
        case (unpack.opcode)
            OP_RTYPE:  ctl = rtype_ctl;
            OP_REGIMM: ctl = regimm_ctl;

            OP_J, OP_JAL: begin
                ctl.pc_src  = PC_SRC_JUMP;
                ctl.opd_use = OPERAND_USE_NONE;
                if (unpack.opcode == OP_JAL) begin
                    ctl.write_reg = 1'b1;
                    ctl.reg_src   = REG_SRC_PCADD4;
                    ctl.dest_reg  = DEST_REG_31;
                end
            end

            // blez and bgtz carry rt as $0 in the encoding.
            OP_BEQ,  OP_BNE,  OP_BLEZ,  OP_BGTZ,
            OP_BEQL, OP_BNEL, OP_BLEZL, OP_BGTZL: begin
                {ctl.pc_src,    ctl.alu_srca, ctl.alu_srcb} =
                {PC_SRC_BRANCH, ALU_SRCA_RS,  ALU_SRCB_RT};
                case (unpack.opcode)
                    OP_BEQ, OP_BEQL:   ctl.flag_sel = FLAG_EQ;
                    OP_BNE, OP_BNEL:   ctl.flag_sel = FLAG_NE;
                    OP_BLEZ, OP_BLEZL: ctl.flag_sel = FLAG_LE;
                    default:           ctl.flag_sel = FLAG_GT;
                endcase
                // likely forms sit in the 0101xx row.
                ctl.is_likely = (unpack.opcode[5:2] == 4'b0101);
            end

            OP_ADDI, OP_ADDIU: begin
                {ctl.alu_funct, ctl.reg_src,
                 ctl.alu_srca,  ctl.alu_srcb,         ctl.dest_reg} =
                {ALU_ADD,       REG_SRC_ALU,
                 ALU_SRCA_RS,   ALU_SRCB_SIGN_IMMED,  DEST_REG_RT};
                ctl.write_reg = 1'b1;
                if (unpack.opcode == OP_ADDI)
                    ctl.exc_chk = EXC_CHK_OVERFLOW;
            end

            OP_SLTI, OP_SLTIU: begin
                {ctl.alu_funct, ctl.reg_src,
                 ctl.alu_srca,  ctl.alu_srcb,         ctl.dest_reg} =
                {ALU_ADD,       REG_SRC_FLAG,
                 ALU_SRCA_RS,   ALU_SRCB_SIGN_IMMED,  DEST_REG_RT};
                ctl.flag_sel  = (unpack.opcode == OP_SLTIU) ? FLAG_LTU : FLAG_LT;
                ctl.write_reg = 1'b1;
            end

            OP_ANDI, OP_ORI, OP_XORI: begin
                {ctl.reg_src,   ctl.alu_srca,
                 ctl.alu_srcb,  ctl.dest_reg} =
                {REG_SRC_ALU,   ALU_SRCA_RS,
                 ALU_SRCB_IMMED, DEST_REG_RT};
                ctl.write_reg = 1'b1;
                case (unpack.opcode)
                    OP_ANDI: ctl.alu_funct = ALU_AND;
                    OP_ORI:  ctl.alu_funct = ALU_OR;
                    default: ctl.alu_funct = ALU_XOR;
                endcase
            end

            OP_LUI: begin
                {ctl.alu_funct, ctl.reg_src,
                 ctl.alu_srca,  ctl.alu_srcb,       ctl.dest_reg} =
                {ALU_ADD,       REG_SRC_ALU,
                 ALU_SRCA_RS,   ALU_SRCB_UP_IMMED,  DEST_REG_RT};
                ctl.write_reg = 1'b1;
            end

            OP_SW: begin
                {ctl.alu_funct, ctl.reg_src,
                 ctl.alu_srca,  ctl.alu_srcb} =
                {ALU_ADD,       REG_SRC_ALU,
                 ALU_SRCA_RS,   ALU_SRCB_SIGN_IMMED};
                ctl.write_mode = MEM_WRITE_WORD;
                ctl.write_mem  = 1'b1;
            end

            // cop0 and special2 land here as well.
            default:
                ctl.exc_chk = EXC_CHK_RESERVED;
        endcase
    end

endmodule

`default_nettype wire

// File: source/mips_decode_pkg.sv
`default_nettype none

package mips_decode_pkg;

    // ************************************************************
    // selector encodings.
    // ************************************************************

    typedef enum logic [3:0] {
        ALU_NCARE, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_funct_e;

    typedef enum logic [1:0] {
        ALU_SRCA_NCARE, ALU_SRCA_RS, ALU_SRCA_SHAMT
    } alu_srca_e;

    // immed is zero extended, sign_immed sign extended, up_immed is imm << 16.
    typedef enum logic [2:0] {
        ALU_SRCB_NCARE, ALU_SRCB_RT, ALU_SRCB_IMMED,
        ALU_SRCB_SIGN_IMMED, ALU_SRCB_UP_IMMED
    } alu_srcb_e;

    typedef enum logic [1:0] {
        DEST_REG_NCARE, DEST_REG_RD, DEST_REG_RT, DEST_REG_31
    } dest_reg_e;

    typedef enum logic [1:0] {
        PC_SRC_NEXT, PC_SRC_JUMP, PC_SRC_BRANCH, PC_SRC_REG
    } pc_src_e;

    typedef enum logic [2:0] {
        FLAG_NCARE, FLAG_EQ, FLAG_NE, FLAG_LE,
        FLAG_GT, FLAG_LT, FLAG_LTU, FLAG_GE
    } flag_sel_e;

    typedef enum logic [2:0] {
        REG_SRC_NCARE, REG_SRC_ALU, REG_SRC_FLAG, REG_SRC_PCADD8, REG_SRC_PCADD4
    } reg_src_e;

    // loads are not decoded yet, one bit keeps the word at 32.
    typedef enum logic [0:0] {
        MEM_READ_NCARE
    } mem_read_e;

    typedef enum logic [1:0] {
        MEM_WRITE_NCARE, MEM_WRITE_WORD
    } mem_write_e;

    typedef enum logic [1:0] {
        OPERAND_USE_BOTH, OPERAND_USE_RS, OPERAND_USE_RT, OPERAND_USE_NONE
    } opd_use_e;

    typedef enum logic [2:0] {
        EXC_CHK_NONE, EXC_CHK_OVERFLOW, EXC_CHK_RESERVED,
        EXC_CHK_SYSCALL, EXC_CHK_BREAK
    } exc_chk_e;

    // ************************************************************
    // control word and instruction fields.
    // ************************************************************

    typedef struct packed {
        alu_funct_e alu_funct;
        alu_srca_e  alu_srca;
        alu_srcb_e  alu_srcb;
        dest_reg_e  dest_reg;
        pc_src_e    pc_src;
        flag_sel_e  flag_sel;
        reg_src_e   reg_src;
        mem_read_e  read_mode;
        mem_write_e write_mode;
        opd_use_e   opd_use;
        exc_chk_e   exc_chk;
        logic       write_reg;
        logic       write_mem;
        logic       is_link;
        logic       is_likely;
        logic       is_priv;
    } control_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;
        logic [15:0] imm;
    } unpack_t;

    localparam control_t CONTROL_DEFAULT = '{
        alu_funct:  ALU_NCARE,
        alu_srca:   ALU_SRCA_NCARE,
        alu_srcb:   ALU_SRCB_NCARE,
        dest_reg:   DEST_REG_NCARE,
        pc_src:     PC_SRC_NEXT,
        flag_sel:   FLAG_NCARE,
        reg_src:    REG_SRC_NCARE,
        read_mode:  MEM_READ_NCARE,
        write_mode: MEM_WRITE_NCARE,
        opd_use:    OPERAND_USE_BOTH,
        exc_chk:    EXC_CHK_NONE,
        default:    1'b0
    };

    // ************************************************************
    // opcode, funct and regimm rt encodings.
    // ************************************************************

    localparam logic [5:0] OP_RTYPE  = 6'b000000;
    localparam logic [5:0] OP_REGIMM = 6'b000001;
    localparam logic [5:0] OP_J      = 6'b000010;
    localparam logic [5:0] OP_JAL    = 6'b000011;
    localparam logic [5:0] OP_BEQ    = 6'b000100;
    localparam logic [5:0] OP_BNE    = 6'b000101;
    localparam logic [5:0] OP_BLEZ   = 6'b000110;
    localparam logic [5:0] OP_BGTZ   = 6'b000111;
    localparam logic [5:0] OP_ADDI   = 6'b001000;
    localparam logic [5:0] OP_ADDIU  = 6'b001001;
    localparam logic [5:0] OP_SLTI   = 6'b001010;
    localparam logic [5:0] OP_SLTIU  = 6'b001011;
    localparam logic [5:0] OP_ANDI   = 6'b001100;
    localparam logic [5:0] OP_ORI    = 6'b001101;
    localparam logic [5:0] OP_XORI   = 6'b001110;
    localparam logic [5:0] OP_LUI    = 6'b001111;
    localparam logic [5:0] OP_BEQL   = 6'b010100;
    localparam logic [5:0] OP_BNEL   = 6'b010101;
    localparam logic [5:0] OP_BLEZL  = 6'b010110;
    localparam logic [5:0] OP_BGTZL  = 6'b010111;
    localparam logic [5:0] OP_SW     = 6'b101011;

    localparam logic [5:0] FN_SLL     = 6'b000000;
    localparam logic [5:0] FN_SRL     = 6'b000010;
    localparam logic [5:0] FN_SRA     = 6'b000011;
    localparam logic [5:0] FN_JR      = 6'b001000;
    localparam logic [5:0] FN_JALR    = 6'b001001;
    localparam logic [5:0] FN_SYSCALL = 6'b001100;
    localparam logic [5:0] FN_BREAK   = 6'b001101;
    localparam logic [5:0] FN_ADD     = 6'b100000;
    localparam logic [5:0] FN_ADDU    = 6'b100001;
    localparam logic [5:0] FN_SUB     = 6'b100010;
    localparam logic [5:0] FN_SUBU    = 6'b100011;
    localparam logic [5:0] FN_AND     = 6'b100100;
    localparam logic [5:0] FN_OR      = 6'b100101;
    localparam logic [5:0] FN_XOR     = 6'b100110;
    localparam logic [5:0] FN_NOR     = 6'b100111;
    localparam logic [5:0] FN_SLT     = 6'b101010;
    localparam logic [5:0] FN_SLTU    = 6'b101011;

    localparam logic [4:0] RI_BLTZ   = 5'b00000;
    localparam logic [4:0] RI_BGEZ   = 5'b00001;
    localparam logic [4:0] RI_BLTZAL = 5'b10000;
    localparam logic [4:0] RI_BGEZAL = 5'b10001;

endpackage

`default_nettype wire

// File: source/regimm_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module regimm_decoder
    import mips_decode_pkg::*;
(
    input  wire unpack_t unpack,
    output control_t     ctl
);

    always_comb begin
        ctl = CONTROL_DEFAULT;
        case (unpack.rt)
            RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL: begin
                // rs is compared against zero, rt is the sub-opcode.
                {ctl.pc_src,       ctl.alu_srca, ctl.opd_use} =
                {PC_SRC_BRANCH,    ALU_SRCA_RS,  OPERAND_USE_RS};
                if (unpack.rt == RI_BLTZ || unpack.rt == RI_BLTZAL)
                    ctl.flag_sel = FLAG_LT;
                else
                    ctl.flag_sel = FLAG_GE;
                if (unpack.rt == RI_BLTZAL || unpack.rt == RI_BGEZAL) begin
                    ctl.reg_src   = REG_SRC_PCADD8;
                    ctl.dest_reg  = DEST_REG_31;
                    ctl.write_reg = 1'b1;
                    ctl.is_link   = 1'b1;
                end
            end
            default:
                ctl.exc_chk = EXC_CHK_RESERVED;
        endcase
    end

endmodule

`default_nettype wire

// File: source/rtype_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module rtype_decoder
    import mips_decode_pkg::*;
(
    input  wire unpack_t unpack,
    output control_t     ctl
);

    always_comb begin
        ctl = CONTROL_DEFAULT;
        case (unpack.funct)
            FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
            FN_AND, FN_OR, FN_XOR, FN_NOR: begin
                {ctl.alu_srca, ctl.alu_srcb, ctl.dest_reg, ctl.reg_src} =
                {ALU_SRCA_RS,  ALU_SRCB_RT,  DEST_REG_RD,  REG_SRC_ALU};
                ctl.write_reg = 1'b1;
                case (unpack.funct)
                    FN_ADD, FN_ADDU: ctl.alu_funct = ALU_ADD;
                    FN_SUB, FN_SUBU: ctl.alu_funct = ALU_SUB;
                    FN_AND:          ctl.alu_funct = ALU_AND;
                    FN_OR:           ctl.alu_funct = ALU_OR;
                    FN_XOR:          ctl.alu_funct = ALU_XOR;
                    default:         ctl.alu_funct = ALU_NOR;
                endcase
                // only the trapping forms check overflow.
                if (unpack.funct == FN_ADD || unpack.funct == FN_SUB)
                    ctl.exc_chk = EXC_CHK_OVERFLOW;
            end

            FN_SLL, FN_SRL, FN_SRA: begin
                {ctl.alu_srca,    ctl.alu_srcb, ctl.dest_reg, ctl.reg_src} =
                {ALU_SRCA_SHAMT,  ALU_SRCB_RT,  DEST_REG_RD,  REG_SRC_ALU};
                ctl.opd_use   = OPERAND_USE_RT;
                ctl.write_reg = 1'b1;
                case (unpack.funct)
                    FN_SLL:  ctl.alu_funct = ALU_SLL;
                    FN_SRL:  ctl.alu_funct = ALU_SRL;
                    default: ctl.alu_funct = ALU_SRA;
                endcase
            end

            FN_SLT, FN_SLTU: begin
                {ctl.alu_funct, ctl.alu_srca, ctl.alu_srcb, ctl.dest_reg, ctl.reg_src} =
                {ALU_SUB,       ALU_SRCA_RS,  ALU_SRCB_RT,  DEST_REG_RD,  REG_SRC_FLAG};
                ctl.flag_sel  = (unpack.funct == FN_SLTU) ? FLAG_LTU : FLAG_LT;
                ctl.write_reg = 1'b1;
            end

            FN_JR: begin
                ctl.pc_src  = PC_SRC_REG;
                ctl.opd_use = OPERAND_USE_RS;
            end

            FN_JALR: begin
                ctl.pc_src    = PC_SRC_REG;
                ctl.opd_use   = OPERAND_USE_RS;
                ctl.reg_src   = REG_SRC_PCADD8;
                ctl.dest_reg  = DEST_REG_RD;
                ctl.write_reg = 1'b1;
                ctl.is_link   = 1'b1;
            end

            FN_SYSCALL: begin
                ctl.opd_use = OPERAND_USE_NONE;
                ctl.exc_chk = EXC_CHK_SYSCALL;
            end

            FN_BREAK: begin
                ctl.opd_use = OPERAND_USE_NONE;
                ctl.exc_chk = EXC_CHK_BREAK;
            end

            default:
                ctl.exc_chk = EXC_CHK_RESERVED;
        endcase
    end

endmodule

`default_nettype wire

// File: tb.f
source/mips_decode_pkg.sv
source/extract_instruction.sv
source/rtype_decoder.sv
source/regimm_decoder.sv
source/main_decoder.sv
source/decode_stage_reg.sv
source/decode_stage.sv
verification/decode_stage_properties.sv
verification/tb_decode_stage.sv

// File: verification/decode_stage_properties.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage_properties
    import mips_decode_pkg::*;
(
    input wire logic     clk,
    input wire logic     rst_n,
    input wire logic     stall,
    input wire logic     flush,
    input wire control_t ctl,
    input wire unpack_t  fields,
    input wire logic     ctl_valid
);

    int failures = 0;

    flush_clears_valid: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !ctl_valid)
        else begin
            $error("ctl_valid high in the cycle after a flush");
            failures++;
        end

    // a stall without flush freezes every output.
    stall_holds_outputs: assert property (@(posedge clk) disable iff (!rst_n)
        (stall && !flush) |=> ($stable(ctl) && $stable(fields) && $stable(ctl_valid)))
        else begin
            $error("outputs changed while stalled");
            failures++;
        end

    valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(ctl_valid))
        else begin
            $error("ctl_valid is unknown after reset");
            failures++;
        end

endmodule

bind decode_stage decode_stage_properties u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .flush     (flush),
    .ctl       (ctl),
    .fields    (fields),
    .ctl_valid (ctl_valid)
);

`default_nettype wire

// File: verification/decode_trace.txt
# name instr(hex) instr_valid stall flush expected_ctl(hex) expected_ctl_valid
# each line is presented for one cycle, the expected values appear one cycle later.
reset_hold   00000000 0 1 0 00000000 0
addi         2109FFFB 1 0 0 15C02030 1
addiu        250A0010 1 0 0 15C02010 1
slti         28828000 1 0 0 15C54010 1
sltiu        2CA30001 1 0 0 15C64010 1
andi         302200FF 1 0 0 35402010 1
ori          34081234 1 0 0 45402010 1
xori         3863AAAA 1 0 0 55402010 1
lui          3C01DEAD 1 0 0 16402010 1
sw           AFBF0004 1 0 0 15802408 1
j            08100040 1 0 0 00080300 1
jal          0C100100 1 0 0 00688310 1
beq          10220003 1 0 0 04910000 1
bne          1464FFFE 1 0 0 04920000 1
blez         18A00010 1 0 0 04930000 1
bgtz         1CC00008 1 0 0 04940000 1
beql         50220003 1 0 0 04910002 1
bnel         54640001 1 0 0 04920002 1
blezl        58A00002 1 0 0 04930002 1
bgtzl        5CC00004 1 0 0 04940002 1
bltz         04E00005 1 0 0 04150100 1
bgez         04E10005 1 0 0 04170100 1
bltzal       04F00005 1 0 0 04756114 1
bgezal       04F10005 1 0 0 04776114 1
add          00221820 1 0 0 14A02030 1
addu         00221821 1 0 0 14A02010 1
sub          00221822 1 0 0 24A02030 1
subu         00221823 1 0 0 24A02010 1
and          00221824 1 0 0 34A02010 1
or           00221825 1 0 0 44A02010 1
xor          00221826 1 0 0 54A02010 1
nor          00221827 1 0 0 64A02010 1
sll          00022140 1 0 0 78A02210 1
srl          00022142 1 0 0 88A02210 1
sra          00022143 1 0 0 98A02210 1
slt          0022182A 1 0 0 24A54010 1
sltu         0022182B 1 0 0 24A64010 1
jr           03E00008 1 0 0 00180100 1
jalr         00A0F809 1 0 0 00386114 1
syscall      0000000C 1 0 0 00000360 1
break        0000000D 1 0 0 00000380 1
rsv_opcode   8C220010 1 0 0 00000040 1
rsv_cop0     40026000 1 0 0 00000040 1
rsv_special2 70221802 1 0 0 00000040 1
rsv_funct    00221801 1 0 0 00000040 1
rsv_regimm   04E20005 1 0 0 00000040 1
flush        00221820 1 0 1 00000000 0
stall_load   2109FFFB 1 0 0 15C02030 1
stall_1      00221820 1 1 0 15C02030 1
stall_2      00221820 1 1 0 15C02030 1
stall_release 00221820 1 0 0 14A02030 1
bubble       34081234 0 0 0 45402010 0
flush_stall  00221820 1 1 1 00000000 0
after_flush  3C01DEAD 1 0 0 16402010 1

// File: verification/tb_decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_decode_stage
    import mips_decode_pkg::*;
;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic        instr_valid;
    logic        stall;
    logic        flush;
    control_t    ctl;
    unpack_t     fields;
    logic        ctl_valid;

    // one entry per trace line.
    string       name_q[$];
    logic [31:0] instr_q[$];
    logic        valid_q[$];
    logic        stall_q[$];
    logic        flush_q[$];
    logic [31:0] ctl_q[$];
    logic        cvalid_q[$];

    int          n_lines = 0;
    int          tests_failed = 0;
    int          checks_failed = 0;
    int          trace_errors = 0;
    bit          loaded = 1'b0;
    unpack_t     exp_fields;

    decode_stage u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .stall       (stall),
        .flush       (flush),
        .ctl         (ctl),
        .fields      (fields),
        .ctl_valid   (ctl_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ************************************************************
    // trace handling.
    // ************************************************************

    function automatic unpack_t slice_fields(input logic [31:0] w);
        unpack_t u;
        u.opcode = w[31:26];
        u.rs     = w[25:21];
        u.rt     = w[20:16];
        u.rd     = w[15:11];
        u.shamt  = w[10:6];
        u.funct  = w[5:0];
        u.imm    = w[15:0];
        return u;
    endfunction

    task automatic read_trace();
        int          fd;
        int          code;
        int          n;
        string       line;
        string       name;
        logic [31:0] word;
        logic [3:0]  v;
        logic [3:0]  s;
        logic [3:0]  f;
        logic [31:0] exp_ctl;
        logic [3:0]  cv;
        fd = $fopen("verification/decode_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/decode_trace.txt");
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0)
                break;
            if (line.len() > 0 && line.getc(0) == "#")
                continue;
            n = $sscanf(line, "%s %h %h %h %h %h %h", name, word, v, s, f, exp_ctl, cv);
            if (n == 7) begin
                name_q.push_back(name);
                instr_q.push_back(word);
                valid_q.push_back(v[0]);
                stall_q.push_back(s[0]);
                flush_q.push_back(f[0]);
                ctl_q.push_back(exp_ctl);
                cvalid_q.push_back(cv[0]);
            end else if (n > 0) begin
                $display("malformed trace line: %s", line);
                trace_errors++;
            end
        end
        $fclose(fd);
        n_lines = name_q.size();
    endtask

    task automatic drive_line(input int i);
        instr       <= instr_q[i];
        instr_valid <= valid_q[i];
        stall       <= stall_q[i];
        flush       <= flush_q[i];
    endtask

    task automatic drive_idle();
        instr       <= '0;
        instr_valid <= 1'b0;
        stall       <= 1'b0;
        flush       <= 1'b0;
    endtask

    // fields follow the register rules, flush first, then stall.
    task automatic check_line(input int i);
        int errs;
        errs = 0;
        if (flush_q[i])
            exp_fields = '0;
        else if (!stall_q[i])
            exp_fields = slice_fields(instr_q[i]);
        assert (ctl === ctl_q[i]) else begin
            $display("Fail %s ctl expected %h actual %h", name_q[i], ctl_q[i], ctl);
            errs++;
        end
        assert (fields === exp_fields) else begin
            $display("Fail %s fields expected %h actual %h", name_q[i], exp_fields, fields);
            errs++;
        end
        assert (ctl_valid === cvalid_q[i]) else begin
            $display("Fail %s ctl_valid expected %b actual %b",
                     name_q[i], cvalid_q[i], ctl_valid);
            errs++;
        end
        checks_failed += errs;
        if (errs == 0) begin
            $display("test %-12s passed", name_q[i]);
        end else begin
            $display("test %-12s failed", name_q[i]);
            tests_failed++;
        end
    endtask

    // ************************************************************
    // main sequence and watchdog.
    // ************************************************************

    initial begin
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        exp_fields  = '0;
        read_trace();
        loaded = 1'b1;
        if (n_lines == 0) begin
            $display("no usable trace lines, nothing was run");
            $display("Test FAILED");
        end else begin
            repeat (10) @(posedge clk);
            rst_n <= 1'b1;
            drive_line(0);
            // line i is captured on the edge that drives line i+1.
            for (int i = 1; i <= n_lines; i++) begin
                @(posedge clk);
                if (i < n_lines)
                    drive_line(i);
                else
                    drive_idle();
                @(negedge clk);
                check_line(i - 1);
            end
            $display("tests run %0d, tests failed %0d, checks failed %0d, property failures %0d",
                     n_lines, tests_failed, checks_failed, u_dut.u_props.failures);
            if (tests_failed == 0 && trace_errors == 0 && u_dut.u_props.failures == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
        end
        $finish;
    end

    initial begin
        wait (loaded);
        #((n_lines + 20) * 10);
        $display("timeout, the trace did not complete within %0d cycles", n_lines + 20);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
